//--- cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// data and instruction word width
`define CPU_DATA_W   32

// 32 registers
`define CPU_REG_AW   5

`define CPU_IMEM_AW  8  // 256 instruction words
`define CPU_DMEM_AW  8  // 256 data words

`endif

//--- isa_pkg.sv
package isa_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // instruction types, bits 31..27
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [4:0] {
      INSTR_LOAD_IMMEDIATE = 5'd1,
      INSTR_LOAD           = 5'd2,
      INSTR_STORE          = 5'd3,
      INSTR_ALU_OP         = 5'd4,
      INSTR_JUMP           = 5'd5,
      INSTR_HALT           = 5'd6
   } instr_type_e;

   // alu opcodes, bits 11..8
   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SLL = 4'd5,
      ALU_SRL = 4'd6,
      ALU_SLT = 4'd7   // signed compare
   } alu_op_e;

   // field positions
   localparam int TYPE_MSB = 31;
   localparam int TYPE_LSB = 27;
   localparam int RD_MSB   = 26;
   localparam int RD_LSB   = 22;
   localparam int RS0_MSB  = 21;
   localparam int RS0_LSB  = 17;
   localparam int RS1_MSB  = 16;
   localparam int RS1_LSB  = 12;
   localparam int OP_MSB   = 11;
   localparam int OP_LSB   = 8;
   localparam int IMM_MSB  = 16;   // overlaps rs1, only one is used per type
   localparam int IMM_LSB  = 0;
   localparam int IMM_W    = IMM_MSB - IMM_LSB + 1;

endpackage

//--- ctrl_pkg.sv
package ctrl_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // execution stages
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // one instruction in flight, each stage lasts one cycle
   typedef enum logic [2:0] {
      STAGE_IDLE            = 3'd0,
      STAGE_FETCH           = 3'd1,
      STAGE_DECODE          = 3'd2,
      STAGE_EXECUTE         = 3'd3,
      STAGE_MEMORY          = 3'd4,
      STAGE_REGISTER_UPDATE = 3'd5,
      STAGE_HALTED          = 3'd6
   } stage_e;

endpackage

//--- stage_sequencer.sv
module stage_sequencer (
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic                 start_i,
   input  isa_pkg::instr_type_e instr_type_i,
   output ctrl_pkg::stage_e     stage_o,
   output logic                 busy_o,
   output logic                 halted_o
);

   ctrl_pkg::stage_e stage_q;
   ctrl_pkg::stage_e stage_d;

   always_comb begin
      stage_d = stage_q;
      case (stage_q)
         ctrl_pkg::STAGE_IDLE,
         ctrl_pkg::STAGE_HALTED: begin
            if (start_i) begin
               stage_d = ctrl_pkg::STAGE_FETCH;
            end
         end
         ctrl_pkg::STAGE_FETCH:   stage_d = ctrl_pkg::STAGE_DECODE;
         ctrl_pkg::STAGE_DECODE: begin
            if (instr_type_i == isa_pkg::INSTR_HALT) begin
               stage_d = ctrl_pkg::STAGE_HALTED;   // halt never executes
            end else begin
               stage_d = ctrl_pkg::STAGE_EXECUTE;
            end
         end
         ctrl_pkg::STAGE_EXECUTE: stage_d = ctrl_pkg::STAGE_MEMORY;
         ctrl_pkg::STAGE_MEMORY:  stage_d = ctrl_pkg::STAGE_REGISTER_UPDATE;
         ctrl_pkg::STAGE_REGISTER_UPDATE: stage_d = ctrl_pkg::STAGE_FETCH;
         default: stage_d = ctrl_pkg::STAGE_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         stage_q <= ctrl_pkg::STAGE_IDLE;
      end else begin
         stage_q <= stage_d;
      end
   end

   assign stage_o  = stage_q;
   assign busy_o   = (stage_q != ctrl_pkg::STAGE_IDLE) && (stage_q != ctrl_pkg::STAGE_HALTED);
   assign halted_o = stage_q == ctrl_pkg::STAGE_HALTED;

endmodule

//--- instr_fetch.sv
`include "cpu_config.svh"

module instr_fetch (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    prog_we_i,
   input  logic [`CPU_IMEM_AW-1:0] prog_addr_i,
   input  logic [`CPU_DATA_W-1:0]  prog_data_i,
   input  logic                    start_i,
   input  ctrl_pkg::stage_e        stage_i,
   input  logic [`CPU_DATA_W-1:0]  rd0_data_i,
   input  logic [`CPU_DATA_W-1:0]  rd1_data_i,
   output isa_pkg::instr_type_e    instr_type_o,
   output logic [`CPU_REG_AW-1:0]  rd_o,
   output logic [`CPU_REG_AW-1:0]  rs0_o,
   output logic [`CPU_REG_AW-1:0]  rs1_o,
   output isa_pkg::alu_op_e        alu_op_o,
   output logic [`CPU_DATA_W-1:0]  imm_o
);

   logic [`CPU_DATA_W-1:0]  imem [0:(1 << `CPU_IMEM_AW)-1];
   logic [`CPU_IMEM_AW-1:0] pc;
   logic [`CPU_DATA_W-1:0]  ir;
   logic                    core_stopped;
   logic                    jump_taken;

   assign core_stopped = (stage_i == ctrl_pkg::STAGE_IDLE) ||
                         (stage_i == ctrl_pkg::STAGE_HALTED);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // instruction memory and instruction register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (prog_we_i && core_stopped) begin
         imem[prog_addr_i] <= prog_data_i;   // loader port
      end
      if (stage_i == ctrl_pkg::STAGE_FETCH) begin
         ir <= imem[pc];
      end
   end

   // condition in rs0, target in rs1
   assign jump_taken = (instr_type_o == isa_pkg::INSTR_JUMP) && (rd0_data_i != '0);

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         pc <= '0;
      end else if (start_i && core_stopped) begin
         pc <= '0;
      end else if (stage_i == ctrl_pkg::STAGE_REGISTER_UPDATE) begin
         if (jump_taken) begin
            pc <= rd1_data_i[`CPU_IMEM_AW-1:0];
         end else begin
            pc <= pc + 1'b1;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // field decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign instr_type_o = isa_pkg::instr_type_e'(ir[isa_pkg::TYPE_MSB:isa_pkg::TYPE_LSB]);
   assign rd_o         = ir[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
   assign rs0_o        = ir[isa_pkg::RS0_MSB:isa_pkg::RS0_LSB];
   assign rs1_o        = ir[isa_pkg::RS1_MSB:isa_pkg::RS1_LSB];
   assign alu_op_o     = isa_pkg::alu_op_e'(ir[isa_pkg::OP_MSB:isa_pkg::OP_LSB]);
   assign imm_o        = {{(`CPU_DATA_W - isa_pkg::IMM_W){ir[isa_pkg::IMM_MSB]}},
                          ir[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB]};   // sign extend

endmodule

//--- register_file_control.sv
`include "cpu_config.svh"

module register_file_control (
   input  ctrl_pkg::stage_e        stage_i,
   input  isa_pkg::instr_type_e    instr_type_i,
   input  logic [`CPU_REG_AW-1:0]  rd_i,
   input  logic [`CPU_REG_AW-1:0]  rs0_i,
   input  logic [`CPU_REG_AW-1:0]  rs1_i,
   input  logic [`CPU_DATA_W-1:0]  imm_i,
   input  logic [`CPU_DATA_W-1:0]  alu_result_i,
   input  logic [`CPU_DATA_W-1:0]  load_data_i,
   output logic [`CPU_REG_AW-1:0]  write_addr_o,
   output logic [`CPU_DATA_W-1:0]  write_data_o,
   output logic                    write_enable_o,
   output logic [`CPU_REG_AW-1:0]  read_reg_0_o,
   output logic [`CPU_REG_AW-1:0]  read_reg_1_o
);

   logic updates_reg_file;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // register port selection per instruction type
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      write_addr_o     = '0;
      write_data_o     = '0;
      read_reg_0_o     = '0;
      read_reg_1_o     = '0;
      updates_reg_file = 1'b0;
      case (instr_type_i)
         isa_pkg::INSTR_LOAD_IMMEDIATE: begin
            write_addr_o     = rd_i;
            write_data_o     = imm_i;
            updates_reg_file = 1'b1;
         end
         isa_pkg::INSTR_LOAD: begin
            write_addr_o     = rd_i;
            write_data_o     = load_data_i;
            read_reg_0_o     = rs0_i;   // memory address
            updates_reg_file = 1'b1;
         end
         isa_pkg::INSTR_ALU_OP: begin
            write_addr_o     = rd_i;
            write_data_o     = alu_result_i;
            read_reg_0_o     = rs0_i;
            read_reg_1_o     = rs1_i;
            updates_reg_file = 1'b1;
         end
         // store: data, address / jump: condition, target
         isa_pkg::INSTR_STORE,
         isa_pkg::INSTR_JUMP: begin
            read_reg_0_o = rs0_i;
            read_reg_1_o = rs1_i;
         end
         default: begin
            updates_reg_file = 1'b0;   // halt and unused codes
         end
      endcase
   end

   assign write_enable_o = (stage_i == ctrl_pkg::STAGE_REGISTER_UPDATE) && updates_reg_file;

endmodule

//--- register_file.sv
`include "cpu_config.svh"

module register_file (
   input  logic                   clk,
   input  logic                   wr_en_i,
   input  logic [`CPU_REG_AW-1:0] wr_addr_i,
   input  logic [`CPU_DATA_W-1:0] wr_data_i,
   input  logic [`CPU_REG_AW-1:0] rd_addr0_i,
   input  logic [`CPU_REG_AW-1:0] rd_addr1_i,
   output logic [`CPU_DATA_W-1:0] rd_data0_o,
   output logic [`CPU_DATA_W-1:0] rd_data1_o
);

   logic [`CPU_DATA_W-1:0] regs [0:(1 << `CPU_REG_AW)-1];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         regs[wr_addr_i] <= wr_data_i;
      end
   end

   // asynchronous read ports
   assign rd_data0_o = regs[rd_addr0_i];
   assign rd_data1_o = regs[rd_addr1_i];

endmodule

//--- alu.sv
`include "cpu_config.svh"

module alu (
   input  logic                   clk,
   input  ctrl_pkg::stage_e       stage_i,
   input  isa_pkg::alu_op_e       op_i,
   input  logic [`CPU_DATA_W-1:0] a_i,
   input  logic [`CPU_DATA_W-1:0] b_i,
   output logic [`CPU_DATA_W-1:0] result_o
);

   logic [`CPU_DATA_W-1:0] result_d;
   logic [`CPU_DATA_W-1:0] result_q;
   logic [4:0]             shamt;

   assign shamt = b_i[4:0];

   always_comb begin
      case (op_i)
         isa_pkg::ALU_ADD: result_d = a_i + b_i;
         isa_pkg::ALU_SUB: result_d = a_i - b_i;
         isa_pkg::ALU_AND: result_d = a_i & b_i;
         isa_pkg::ALU_OR:  result_d = a_i | b_i;
         isa_pkg::ALU_XOR: result_d = a_i ^ b_i;
         isa_pkg::ALU_SLL: result_d = a_i << shamt;
         isa_pkg::ALU_SRL: result_d = a_i >> shamt;
         isa_pkg::ALU_SLT: begin
            result_d = {{(`CPU_DATA_W-1){1'b0}}, $signed(a_i) < $signed(b_i)};
         end
         default: result_d = '0;   // unused opcodes
      endcase
   end

   // result held for the register update stage
   always_ff @(posedge clk) begin
      if (stage_i == ctrl_pkg::STAGE_EXECUTE) begin
         result_q <= result_d;
      end
   end

   assign result_o = result_q;

endmodule

//--- data_memory.sv
`include "cpu_config.svh"

module data_memory (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  ctrl_pkg::stage_e        stage_i,
   input  isa_pkg::instr_type_e    instr_type_i,
   input  logic [`CPU_DATA_W-1:0]  rd0_data_i,
   input  logic [`CPU_DATA_W-1:0]  rd1_data_i,
   output logic [`CPU_DATA_W-1:0]  load_data_o,
   output logic                    st_valid_o,
   output logic [`CPU_DMEM_AW-1:0] st_addr_o,
   output logic [`CPU_DATA_W-1:0]  st_data_o
);

   logic [`CPU_DATA_W-1:0] dmem [0:(1 << `CPU_DMEM_AW)-1];
   logic [`CPU_DATA_W-1:0] load_data_q;
   logic                   st_valid_q;

   // strobe raised at end of EXECUTE so it covers exactly the MEMORY cycle
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         st_valid_q <= 1'b0;
      end else begin
         st_valid_q <= (stage_i == ctrl_pkg::STAGE_EXECUTE) &&
                       (instr_type_i == isa_pkg::INSTR_STORE);
      end
   end

   always_ff @(posedge clk) begin
      if (stage_i == ctrl_pkg::STAGE_MEMORY) begin
         load_data_q <= dmem[rd0_data_i[`CPU_DMEM_AW-1:0]];   // load address in rs0
         if (st_valid_q) begin
            dmem[st_addr_o] <= st_data_o;
         end
      end
   end

   assign load_data_o = load_data_q;
   assign st_valid_o  = st_valid_q;
   assign st_addr_o   = rd1_data_i[`CPU_DMEM_AW-1:0];   // address in rs1
   assign st_data_o   = rd0_data_i;

endmodule

//--- cpu_top.sv
`include "cpu_config.svh"

module cpu_top (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    prog_we_i,
   input  logic [`CPU_IMEM_AW-1:0] prog_addr_i,
   input  logic [`CPU_DATA_W-1:0]  prog_data_i,
   input  logic                    start_i,
   output logic                    busy_o,
   output logic                    halted_o,
   output logic                    st_valid_o,
   output logic [`CPU_DMEM_AW-1:0] st_addr_o,
   output logic [`CPU_DATA_W-1:0]  st_data_o
);

   ctrl_pkg::stage_e       stage;
   isa_pkg::instr_type_e   instr_type;
   isa_pkg::alu_op_e       alu_op;
   logic [`CPU_REG_AW-1:0] rd;
   logic [`CPU_REG_AW-1:0] rs0;
   logic [`CPU_REG_AW-1:0] rs1;
   logic [`CPU_DATA_W-1:0] imm;
   logic [`CPU_REG_AW-1:0] wr_addr;
   logic [`CPU_DATA_W-1:0] wr_data;
   logic                   wr_en;
   logic [`CPU_REG_AW-1:0] rd_addr0;
   logic [`CPU_REG_AW-1:0] rd_addr1;
   logic [`CPU_DATA_W-1:0] rd0_data;
   logic [`CPU_DATA_W-1:0] rd1_data;
   logic [`CPU_DATA_W-1:0] alu_result;
   logic [`CPU_DATA_W-1:0] load_data;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // control and fetch
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   stage_sequencer seq0 (
      .clk(clk), .rst_n_i(rst_n_i), .start_i(start_i), .instr_type_i(instr_type),
      .stage_o(stage), .busy_o(busy_o), .halted_o(halted_o)
   );

   instr_fetch fetch0 (
      .clk(clk), .rst_n_i(rst_n_i), .prog_we_i(prog_we_i), .prog_addr_i(prog_addr_i),
      .prog_data_i(prog_data_i), .start_i(start_i), .stage_i(stage),
      .rd0_data_i(rd0_data), .rd1_data_i(rd1_data), .instr_type_o(instr_type),
      .rd_o(rd), .rs0_o(rs0), .rs1_o(rs1), .alu_op_o(alu_op), .imm_o(imm)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // register path, alu and data memory
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   register_file_control rfc0 (
      .stage_i(stage), .instr_type_i(instr_type), .rd_i(rd), .rs0_i(rs0), .rs1_i(rs1),
      .imm_i(imm), .alu_result_i(alu_result), .load_data_i(load_data),
      .write_addr_o(wr_addr), .write_data_o(wr_data), .write_enable_o(wr_en),
      .read_reg_0_o(rd_addr0), .read_reg_1_o(rd_addr1)
   );

   register_file rf0 (
      .clk(clk), .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
      .rd_addr0_i(rd_addr0), .rd_addr1_i(rd_addr1),
      .rd_data0_o(rd0_data), .rd_data1_o(rd1_data)
   );

   alu alu0 (
      .clk(clk), .stage_i(stage), .op_i(alu_op), .a_i(rd0_data), .b_i(rd1_data),
      .result_o(alu_result)
   );

   data_memory dmem0 (
      .clk(clk), .rst_n_i(rst_n_i), .stage_i(stage), .instr_type_i(instr_type),
      .rd0_data_i(rd0_data), .rd1_data_i(rd1_data), .load_data_o(load_data),
      .st_valid_o(st_valid_o), .st_addr_o(st_addr_o), .st_data_o(st_data_o)
   );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;   // period 10
   end

   // low across the first 4 rising edges
   initial begin
      rst_n_o = 1'b0;
      repeat (4) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

//--- tb_cpu.sv
`include "cpu_config.svh"

module tb_cpu;

   localparam int TIMEOUT_CYCLES = 1000;

   logic                    clk;
   logic                    rst_n;
   logic                    prog_we_i;
   logic [`CPU_IMEM_AW-1:0] prog_addr_i;
   logic [`CPU_DATA_W-1:0]  prog_data_i;
   logic                    start_i;
   logic                    busy_o;
   logic                    halted_o;
   logic                    st_valid_o;
   logic [`CPU_DMEM_AW-1:0] st_addr_o;
   logic [`CPU_DATA_W-1:0]  st_data_o;

   logic [`CPU_DATA_W-1:0]  prog [$];
   logic [`CPU_DMEM_AW-1:0] exp_addr [$];
   logic [`CPU_DATA_W-1:0]  exp_data [$];
   logic [`CPU_DMEM_AW-1:0] seen_addr [$];
   logic [`CPU_DATA_W-1:0]  seen_data [$];

   tb_clock_gen clkgen0 (.clk_o(clk), .rst_n_o(rst_n));

   cpu_top dut0 (
      .clk(clk), .rst_n_i(rst_n), .prog_we_i(prog_we_i), .prog_addr_i(prog_addr_i),
      .prog_data_i(prog_data_i), .start_i(start_i), .busy_o(busy_o), .halted_o(halted_o),
      .st_valid_o(st_valid_o), .st_addr_o(st_addr_o), .st_data_o(st_data_o)
   );

   // strobe and bus are settled just before the rising edge
   always @(posedge clk) begin
      if (rst_n && st_valid_o) begin
         seen_addr.push_back(st_addr_o);
         seen_data.push_back(st_data_o);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // checks and waits
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic abort_run();
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_store(
      input logic [`CPU_DMEM_AW-1:0] exp_a,
      input logic [`CPU_DATA_W-1:0]  exp_d,
      input logic [`CPU_DMEM_AW-1:0] act_a,
      input logic [`CPU_DATA_W-1:0]  act_d
   );
      if (act_a !== exp_a) begin
         $display("FAIL t=%0t st_addr_o expected 0x%h actual 0x%h", $time, exp_a, act_a);
         abort_run();
      end else if (act_d !== exp_d) begin
         $display("FAIL t=%0t st_data_o expected 0x%h actual 0x%h", $time, exp_d, act_d);
         abort_run();
      end
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (!rst_n && n < TIMEOUT_CYCLES) begin
         @(negedge clk);
         n++;
      end
      if (!rst_n) begin
         $display("timeout: reset was never released");
         abort_run();
      end
   endtask

   task automatic wait_store_count(input int count);
      int n;
      n = 0;
      while (seen_addr.size() < count && n < TIMEOUT_CYCLES) begin
         @(negedge clk);
         n++;
      end
      if (seen_addr.size() < count) begin
         $display("timeout: saw %0d of %0d store strobes", seen_addr.size(), count);
         abort_run();
      end
   endtask

   task automatic wait_halted();
      int n;
      n = 0;
      while (!halted_o && n < TIMEOUT_CYCLES) begin
         check_flag("busy_o", 1'b1, busy_o);   // busy for the whole run
         @(negedge clk);
         n++;
      end
      if (!halted_o) begin
         $display("timeout: core did not reach halt within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   endtask

   task automatic compare_stores();
      if (seen_addr.size() != exp_addr.size()) begin
         $display("wrong number of stores: expected %0d, saw %0d",
                  exp_addr.size(), seen_addr.size());
         abort_run();
      end else begin
         foreach (exp_addr[i]) begin
            check_store(exp_addr[i], exp_data[i], seen_addr[i], seen_data[i]);
         end
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // program assembly and expected values
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [`CPU_REG_AW-1:0] reg_idx(input int r);
      return r[`CPU_REG_AW-1:0];
   endfunction

   function automatic logic [`CPU_DATA_W-1:0] pack_instr(
      input isa_pkg::instr_type_e   t,
      input logic [`CPU_REG_AW-1:0] rd,
      input logic [`CPU_REG_AW-1:0] rs0,
      input logic [`CPU_REG_AW-1:0] rs1,
      input isa_pkg::alu_op_e       op
   );
      logic [`CPU_DATA_W-1:0] w;
      w = '0;
      w[isa_pkg::TYPE_MSB:isa_pkg::TYPE_LSB] = t;
      w[isa_pkg::RD_MSB:isa_pkg::RD_LSB]     = rd;
      w[isa_pkg::RS0_MSB:isa_pkg::RS0_LSB]   = rs0;
      w[isa_pkg::RS1_MSB:isa_pkg::RS1_LSB]   = rs1;
      w[isa_pkg::OP_MSB:isa_pkg::OP_LSB]     = op;
      return w;
   endfunction

   task automatic load_imm_instr(input int rd, input logic [`CPU_DATA_W-1:0] value);
      logic [`CPU_DATA_W-1:0] w;
      w = pack_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, reg_idx(rd), '0, '0, isa_pkg::ALU_ADD);
      w[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB] = value[16:0];   // rs1 field is overwritten
      prog.push_back(w);
   endtask

   task automatic load_instr(input int rd, input int addr_reg);
      prog.push_back(pack_instr(isa_pkg::INSTR_LOAD, reg_idx(rd), reg_idx(addr_reg), '0,
                                isa_pkg::ALU_ADD));
   endtask

   task automatic store_instr(input int data_reg, input int addr_reg);
      prog.push_back(pack_instr(isa_pkg::INSTR_STORE, '0, reg_idx(data_reg),
                                reg_idx(addr_reg), isa_pkg::ALU_ADD));
   endtask

   task automatic alu_instr(input isa_pkg::alu_op_e op, input int rd, input int a, input int b);
      prog.push_back(pack_instr(isa_pkg::INSTR_ALU_OP, reg_idx(rd), reg_idx(a), reg_idx(b), op));
   endtask

   task automatic jump_instr(input int cond_reg, input int target_reg);
      prog.push_back(pack_instr(isa_pkg::INSTR_JUMP, '0, reg_idx(cond_reg),
                                reg_idx(target_reg), isa_pkg::ALU_ADD));
   endtask

   task automatic halt_instr();
      prog.push_back(pack_instr(isa_pkg::INSTR_HALT, '0, '0, '0, isa_pkg::ALU_ADD));
   endtask

   task automatic expect_store(input int addr, input logic [`CPU_DATA_W-1:0] data);
      exp_addr.push_back(addr[`CPU_DMEM_AW-1:0]);
      exp_data.push_back(data);
   endtask

   function automatic logic [`CPU_DATA_W-1:0] sign_extend_imm(input logic [16:0] v);
      return {{15{v[16]}}, v};
   endfunction

   function automatic logic [`CPU_DATA_W-1:0] alu_expect(
      input isa_pkg::alu_op_e       op,
      input logic [`CPU_DATA_W-1:0] a,
      input logic [`CPU_DATA_W-1:0] b
   );
      int sa;
      int sb;
      sa = a;
      sb = b;
      case (op)
         isa_pkg::ALU_ADD: return a + b;
         isa_pkg::ALU_SUB: return a - b;
         isa_pkg::ALU_AND: return a & b;
         isa_pkg::ALU_OR:  return a | b;
         isa_pkg::ALU_XOR: return a ^ b;
         isa_pkg::ALU_SLL: return a << b[4:0];
         isa_pkg::ALU_SRL: return a >> b[4:0];
         isa_pkg::ALU_SLT: return (sa < sb) ? 32'd1 : 32'd0;
         default:          return '0;
      endcase
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // loading and running
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic new_test();
      prog.delete();
      exp_addr.delete();
      exp_data.delete();
   endtask

   task automatic load_program();
      foreach (prog[i]) begin
         prog_we_i   = 1'b1;
         prog_addr_i = i[`CPU_IMEM_AW-1:0];
         prog_data_i = prog[i];
         @(negedge clk);
      end
      prog_we_i = 1'b0;
   endtask

   // mid_pulse > 0 gives a second start pulse that many cycles into the run
   task automatic run_program(input int mid_pulse);
      seen_addr.delete();
      seen_data.delete();
      start_i = 1'b1;
      @(negedge clk);
      start_i = 1'b0;
      check_flag("halted_o", 1'b0, halted_o);
      check_flag("busy_o", 1'b1, busy_o);
      if (mid_pulse > 0) begin
         repeat (mid_pulse) @(negedge clk);
         check_flag("busy_o", 1'b1, busy_o);
         start_i = 1'b1;
         @(negedge clk);
         start_i = 1'b0;
      end
      wait_store_count(exp_addr.size());
      wait_halted();
      check_flag("busy_o", 1'b0, busy_o);
      check_flag("st_valid_o", 1'b0, st_valid_o);
      compare_stores();
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // directed tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic test_imm_store();
      logic [`CPU_DATA_W-1:0] pos_val;
      logic [`CPU_DATA_W-1:0] neg_val;
      pos_val = $urandom() & 32'h0000_ffff;   // imm bit 16 clear
      neg_val = $urandom() | 32'h0001_0000;   // imm bit 16 set
      new_test();
      load_imm_instr(1, pos_val);
      load_imm_instr(2, neg_val);
      load_imm_instr(3, -5);
      load_imm_instr(4, 16);
      load_imm_instr(5, 3);
      alu_instr(isa_pkg::ALU_ADD, 6, 4, 5);   // address 19
      store_instr(1, 4);
      store_instr(2, 6);
      store_instr(3, 5);
      halt_instr();
      expect_store(16, sign_extend_imm(pos_val[16:0]));
      expect_store(19, sign_extend_imm(neg_val[16:0]));
      expect_store(3, 32'hffff_fffb);
      load_program();
      run_program(0);
   endtask

   task automatic test_alu_ops();
      isa_pkg::alu_op_e       ops [0:7];
      logic [`CPU_DATA_W-1:0] a;
      logic [`CPU_DATA_W-1:0] b;
      ops = '{isa_pkg::ALU_ADD, isa_pkg::ALU_SUB, isa_pkg::ALU_AND, isa_pkg::ALU_OR,
              isa_pkg::ALU_XOR, isa_pkg::ALU_SLL, isa_pkg::ALU_SRL, isa_pkg::ALU_SLT};
      new_test();
      foreach (ops[i]) begin
         a = $urandom();
         b = $urandom();
         load_imm_instr(1, a);
         load_imm_instr(2, b);
         alu_instr(ops[i], 3, 1, 2);
         load_imm_instr(4, 32 + i);
         store_instr(3, 4);
         expect_store(32 + i, alu_expect(ops[i], sign_extend_imm(a[16:0]),
                                         sign_extend_imm(b[16:0])));
      end
      halt_instr();
      load_program();
      run_program(0);
   endtask

   task automatic test_load_after_store();
      logic [`CPU_DATA_W-1:0] v;
      v = $urandom();
      new_test();
      load_imm_instr(1, v);
      load_imm_instr(2, 77);
      load_imm_instr(3, 78);
      store_instr(1, 2);
      load_instr(7, 2);   // read back into another register
      store_instr(7, 3);
      halt_instr();
      expect_store(77, sign_extend_imm(v[16:0]));
      expect_store(78, sign_extend_imm(v[16:0]));
      load_program();
      run_program(0);
   endtask

   task automatic test_jumps();
      new_test();
      load_imm_instr(1, 1);       // 0: nonzero condition
      load_imm_instr(3, 0);       // 1: zero condition
      load_imm_instr(4, 100);     // 2
      load_imm_instr(5, 'h111);   // 3
      load_imm_instr(6, 'h222);   // 4
      load_imm_instr(7, 'h333);   // 5
      load_imm_instr(2, 9);       // 6
      jump_instr(1, 2);           // 7: taken to 9
      store_instr(5, 4);          // 8: skipped
      store_instr(6, 4);          // 9
      load_imm_instr(2, 8);       // 10: backward target
      jump_instr(3, 2);           // 11: not taken
      store_instr(7, 4);          // 12
      store_instr(5, 4);          // 13
      halt_instr();               // 14
      expect_store(100, 'h222);
      expect_store(100, 'h333);
      expect_store(100, 'h111);
      load_program();
      run_program(0);
   endtask

   task automatic test_restart();
      new_test();
      load_imm_instr(1, 'h5a5);
      load_imm_instr(2, 40);
      store_instr(1, 2);
      load_imm_instr(1, 'h0a0);
      load_imm_instr(2, 41);
      store_instr(1, 2);
      halt_instr();
      expect_store(40, 'h5a5);
      expect_store(41, 'h0a0);
      load_program();
      run_program(13);   // extra start lands while busy
      new_test();
      load_imm_instr(1, -1);
      load_imm_instr(2, 250);
      store_instr(1, 2);
      halt_instr();
      expect_store(250, 32'hffff_ffff);
      load_program();
      run_program(0);
   endtask

   initial begin
      int unsigned seed_ret;
      prog_we_i   = 1'b0;
      prog_addr_i = '0;
      prog_data_i = '0;
      start_i     = 1'b0;
      seed_ret    = $urandom(32'habdd9d0b);
      wait_reset_release();
      @(negedge clk);
      check_flag("busy_o", 1'b0, busy_o);
      check_flag("halted_o", 1'b0, halted_o);
      check_flag("st_valid_o", 1'b0, st_valid_o);
      test_imm_store();
      test_alu_ops();
      test_load_after_store();
      test_jumps();
      test_restart();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
stage_sequencer.sv
instr_fetch.sv
register_file_control.sv
register_file.sv
alu.sv
data_memory.sv
cpu_top.sv
tb_clock_gen.sv
tb_cpu.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_cpu
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
